// ==== verilog/egress_cfg_pkg.sv ====
/* Fixed sizes of the egress input bus and of the port index.
   Imported by the demux, the width converter and the top level. */

package egress_cfg_pkg;

    ////////////////////
    // Input word geometry

    // Bytes carried by one input beat
    localparam int DATA_BYTES = 8;

    // Data bits per input beat
    localparam int DATA_W = DATA_BYTES * 8;

    ////////////////////
    // Port addressing

    // Upper bound on 8-bit plus 32-bit ports together
    localparam int MAX_PORTS = 8;

    // Enough bits to address MAX_PORTS ports
    localparam int PORT_IDX_W = 3;

    // Port index as carried on the input sideband
    typedef logic [PORT_IDX_W-1:0] port_idx_t;

endpackage

// ==== verilog/axis_word_pkg.sv ====
/* Data word and keep mask types shared by the buffers and the width
   converters. The union gives byte and dword views of one stored word. */

package axis_word_pkg;

    import egress_cfg_pkg::*;

    ////////////////////
    // Word types

    // One input data word, decoded per byte for 8-bit lanes
    // and per dword for 32-bit lanes
    typedef union packed {
        logic [DATA_W-1:0]                raw;
        logic [DATA_BYTES-1:0][7:0]       bytes;
        logic [DATA_BYTES/4-1:0][31:0]    dwords;
    } axis_word_u;

    // Bit i set means byte i of the word is valid
    typedef logic [DATA_BYTES-1:0] keep_t;

endpackage

// ==== verilog/egress_port_demux.sv ====
/* Registers the input stream and steers each beat to the buffer of its
   port. The port is taken from the first beat of a packet. */

module egress_port_demux
    import egress_cfg_pkg::*;
    import axis_word_pkg::*;
#(
    parameter int NUM_PORTS = 6
) (
    input  logic                  clk_ifc,
    input  logic                  rst_n,
    input  logic [DATA_W-1:0]     s_tdata,
    input  keep_t                 s_tkeep,
    input  logic                  s_tlast,
    input  logic                  s_tvalid,
    input  port_idx_t             s_tport,
    output logic [NUM_PORTS-1:0]  wr_en,
    output axis_word_u            wr_word,
    output keep_t                 wr_keep,
    output logic                  wr_last
);

    logic       in_pkt;
    port_idx_t  pkt_port;
    port_idx_t  cur_port;

    // Mid-packet beats follow the port latched on the first beat
    assign cur_port = in_pkt ? pkt_port : s_tport;

    ////////////////////
    // Packet tracking

    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            in_pkt   <= 1'b0;
            pkt_port <= '0;
        end else if (s_tvalid) begin
            in_pkt <= !s_tlast;
            if (!in_pkt) begin
                pkt_port <= s_tport;
            end
        end
    end

    // One-hot write strobe; an out-of-range index matches no port
    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            wr_en <= '0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                wr_en[p] <= s_tvalid && (cur_port == port_idx_t'(p));
            end
        end
    end

    ////////////////////
    // Beat payload

    always_ff @(posedge clk_ifc) begin
        if (s_tvalid) begin
            wr_word.raw <= s_tdata;
            wr_keep     <= s_tkeep;
            wr_last     <= s_tlast;
        end
    end

endmodule

// ==== verilog/egress_pkt_buffer.sv ====
/* Store-and-forward packet buffer for one egress port. A packet that does
   not fit is dropped whole and reported on overflow for one cycle. */

module egress_pkt_buffer
    import axis_word_pkg::*;
#(
    // Depth in words, a power of two
    parameter int BUF_WORDS = 16
) (
    input  logic        clk_ifc,
    input  logic        rst_n,
    input  logic        wr_en,
    input  axis_word_u  wr_word,
    input  keep_t       wr_keep,
    input  logic        wr_last,
    input  logic        rd_ready,
    output axis_word_u  rd_word,
    output keep_t       rd_keep,
    output logic        rd_last,
    output logic        rd_valid,
    output logic        overflow
);

    localparam int AW    = $clog2(BUF_WORDS);
    // Extra wrap bit tells a full buffer from an empty one
    localparam int PTR_W = AW + 1;

    axis_word_u  mem_word [BUF_WORDS];
    keep_t       mem_keep [BUF_WORDS];
    logic        mem_last [BUF_WORDS];

    logic [PTR_W-1:0]  spec_ptr;
    logic [PTR_W-1:0]  commit_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W-1:0]  fill;
    logic              dropping;
    logic              full;
    logic              wr_accept;
    logic              avail;
    logic              rd_load;

    // Occupancy counts speculative words as well
    assign fill      = spec_ptr - rd_ptr;
    assign full      = (fill == PTR_W'(BUF_WORDS));
    assign wr_accept = wr_en && !dropping && !full;

    // Only whole packets are visible to the read side
    assign avail   = (rd_ptr != commit_ptr);
    assign rd_load = avail && (!rd_valid || rd_ready);

    ////////////////////
    // Write side

    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            spec_ptr   <= '0;
            commit_ptr <= '0;
            dropping   <= 1'b0;
            overflow   <= 1'b0;
        end else begin
            overflow <= 1'b0;
            if (wr_en) begin
                if (dropping) begin
                    // Swallow the tail of a dropped packet
                    if (wr_last) begin
                        dropping <= 1'b0;
                    end
                end else if (full) begin
                    // Rewind to the last packet boundary
                    spec_ptr <= commit_ptr;
                    overflow <= 1'b1;
                    dropping <= !wr_last;
                end else begin
                    spec_ptr <= spec_ptr + 1'b1;
                    if (wr_last) begin
                        commit_ptr <= spec_ptr + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (wr_accept) begin
            mem_word[spec_ptr[AW-1:0]] <= wr_word;
            mem_keep[spec_ptr[AW-1:0]] <= wr_keep;
            mem_last[spec_ptr[AW-1:0]] <= wr_last;
        end
    end

    ////////////////////
    // Read side

    // Output register refills in the same cycle it is drained
    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr   <= '0;
            rd_valid <= 1'b0;
        end else if (rd_load) begin
            rd_ptr   <= rd_ptr + 1'b1;
            rd_valid <= 1'b1;
        end else if (rd_ready) begin
            rd_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (rd_load) begin
            rd_word <= mem_word[rd_ptr[AW-1:0]];
            rd_keep <= mem_keep[rd_ptr[AW-1:0]];
            rd_last <= mem_last[rd_ptr[AW-1:0]];
        end
    end

endmodule

// ==== verilog/egress_width_conv.sv ====
/* Splits buffered 64-bit words into lanes of LANE_BYTES bytes for one
   egress port, trimming the final word to its highest kept byte. */

module egress_width_conv
    import egress_cfg_pkg::*;
    import axis_word_pkg::*;
#(
    // Lane width in bytes, 1 or 4
    parameter int LANE_BYTES = 1
) (
    input  logic                     clk_ifc,
    input  logic                     rst_n,
    input  axis_word_u               rd_word,
    input  keep_t                    rd_keep,
    input  logic                     rd_last,
    input  logic                     rd_valid,
    input  logic                     m_tready,
    output logic                     rd_ready,
    output logic [LANE_BYTES*8-1:0]  m_tdata,
    output logic [LANE_BYTES-1:0]    m_tkeep,
    output logic                     m_tvalid,
    output logic                     m_tlast
);

    localparam int LANES  = DATA_BYTES / LANE_BYTES;
    localparam int LANE_W = $clog2(LANES);

    axis_word_u         word_q;
    keep_t              keep_q;
    logic               last_q;
    logic [LANE_W-1:0]  lane_q;
    logic [LANE_W-1:0]  end_lane_q;
    logic               final_lane;

    // Lane holding the highest kept byte of a word
    function automatic logic [LANE_W-1:0] top_lane(input keep_t keep);
        int hi;
        hi = 0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            if (keep[i]) begin
                hi = i;
            end
        end
        return LANE_W'(hi / LANE_BYTES);
    endfunction

    assign final_lane = (lane_q == end_lane_q);

    // Next word is taken as the current one finishes without a bubble
    assign rd_ready = !m_tvalid || (m_tready && final_lane);

    ////////////////////
    // Lane stepping

    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            m_tvalid <= 1'b0;
            lane_q   <= '0;
        end else if (rd_ready) begin
            m_tvalid <= rd_valid;
            lane_q   <= '0;
        end else if (m_tready) begin
            lane_q <= lane_q + 1'b1;
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (rd_ready && rd_valid) begin
            word_q     <= rd_word;
            keep_q     <= rd_keep;
            last_q     <= rd_last;
            end_lane_q <= rd_last ? top_lane(rd_keep) : LANE_W'(LANES - 1);
        end
    end

    ////////////////////
    // Lane output

    if (LANE_BYTES == 1) begin : g_byte_lane
        assign m_tdata = word_q.bytes[lane_q];
    end else begin : g_dword_lane
        assign m_tdata = word_q.dwords[lane_q];
    end

    assign m_tkeep = keep_q[lane_q*LANE_BYTES +: LANE_BYTES];
    assign m_tlast = last_q && final_lane;

endmodule

// ==== verilog/mpls_egress.sv ====
/* MPLS egress top level that demuxes the 64-bit stream to per-port buffers
   and width converters. 8-bit ports take the low indices and 32-bit ports follow. */

module mpls_egress
    import egress_cfg_pkg::*;
    import axis_word_pkg::*;
#(
    parameter int NUM_8B_PORTS  = 3,
    parameter int NUM_32B_PORTS = 3,
    parameter int BUF_WORDS     = 16
) (
    input  logic                          clk_ifc,
    input  logic                          rst_n,
    input  logic [DATA_W-1:0]             s_tdata,
    input  keep_t                         s_tkeep,
    input  logic                          s_tlast,
    input  logic                          s_tvalid,
    input  port_idx_t                     s_tport,
    output logic [NUM_8B_PORTS*8-1:0]     m8_tdata,
    output logic [NUM_8B_PORTS-1:0]       m8_tvalid,
    output logic [NUM_8B_PORTS-1:0]       m8_tlast,
    input  logic [NUM_8B_PORTS-1:0]       m8_tready,
    output logic [NUM_32B_PORTS*32-1:0]   m32_tdata,
    output logic [NUM_32B_PORTS*4-1:0]    m32_tkeep,
    output logic [NUM_32B_PORTS-1:0]      m32_tvalid,
    output logic [NUM_32B_PORTS-1:0]      m32_tlast,
    input  logic [NUM_32B_PORTS-1:0]      m32_tready,
    output logic [NUM_8B_PORTS-1:0]       overflow_8b,
    output logic [NUM_32B_PORTS-1:0]      overflow_32b
);

    localparam int NUM_PORTS = NUM_8B_PORTS + NUM_32B_PORTS;

    if (NUM_PORTS > MAX_PORTS) begin : g_bad_cfg
        $error("Port count exceeds the port index range");
    end

    logic [NUM_PORTS-1:0]  wr_en;
    axis_word_u            wr_word;
    keep_t                 wr_keep;
    logic                  wr_last;

    egress_port_demux #(
        .NUM_PORTS (NUM_PORTS)
    ) u_demux (
        .clk_ifc  (clk_ifc),
        .rst_n    (rst_n),
        .s_tdata  (s_tdata),
        .s_tkeep  (s_tkeep),
        .s_tlast  (s_tlast),
        .s_tvalid (s_tvalid),
        .s_tport  (s_tport),
        .wr_en    (wr_en),
        .wr_word  (wr_word),
        .wr_keep  (wr_keep),
        .wr_last  (wr_last)
    );

    ////////////////////
    // 8-bit ports

    for (genvar i = 0; i < NUM_8B_PORTS; i++) begin : g_port_8b
        axis_word_u  rd_word;
        keep_t       rd_keep;
        logic        rd_last;
        logic        rd_valid;
        logic        rd_ready;

        egress_pkt_buffer #(.BUF_WORDS(BUF_WORDS)) u_buf (
            .clk_ifc (clk_ifc), .rst_n (rst_n),
            .wr_en (wr_en[i]), .wr_word (wr_word), .wr_keep (wr_keep), .wr_last (wr_last),
            .rd_ready (rd_ready), .rd_word (rd_word), .rd_keep (rd_keep),
            .rd_last (rd_last), .rd_valid (rd_valid), .overflow (overflow_8b[i])
        );

        // Final-lane keep is not carried on a single-byte lane
        egress_width_conv #(.LANE_BYTES(1)) u_conv (
            .clk_ifc (clk_ifc), .rst_n (rst_n),
            .rd_word (rd_word), .rd_keep (rd_keep), .rd_last (rd_last),
            .rd_valid (rd_valid), .m_tready (m8_tready[i]), .rd_ready (rd_ready),
            .m_tdata (m8_tdata[i*8 +: 8]), .m_tkeep (),
            .m_tvalid (m8_tvalid[i]), .m_tlast (m8_tlast[i])
        );
    end

    ////////////////////
    // 32-bit ports

    for (genvar i = 0; i < NUM_32B_PORTS; i++) begin : g_port_32b
        axis_word_u  rd_word;
        keep_t       rd_keep;
        logic        rd_last;
        logic        rd_valid;
        logic        rd_ready;

        egress_pkt_buffer #(.BUF_WORDS(BUF_WORDS)) u_buf (
            .clk_ifc (clk_ifc), .rst_n (rst_n),
            .wr_en (wr_en[NUM_8B_PORTS + i]), .wr_word (wr_word),
            .wr_keep (wr_keep), .wr_last (wr_last),
            .rd_ready (rd_ready), .rd_word (rd_word), .rd_keep (rd_keep),
            .rd_last (rd_last), .rd_valid (rd_valid), .overflow (overflow_32b[i])
        );

        egress_width_conv #(.LANE_BYTES(4)) u_conv (
            .clk_ifc (clk_ifc), .rst_n (rst_n),
            .rd_word (rd_word), .rd_keep (rd_keep), .rd_last (rd_last),
            .rd_valid (rd_valid), .m_tready (m32_tready[i]), .rd_ready (rd_ready),
            .m_tdata (m32_tdata[i*32 +: 32]), .m_tkeep (m32_tkeep[i*4 +: 4]),
            .m_tvalid (m32_tvalid[i]), .m_tlast (m32_tlast[i])
        );
    end

endmodule

// ==== bench/mpls_egress_sva.sv ====
/* Egress port protocol checks bound into mpls_egress.
   The testbench reads fail_count for its closing summary. */

module mpls_egress_sva #(
    parameter int NUM_8B_PORTS  = 3,
    parameter int NUM_32B_PORTS = 3
) (
    input logic                        clk_ifc,
    input logic                        rst_n,
    input logic [NUM_8B_PORTS*8-1:0]   m8_tdata,
    input logic [NUM_8B_PORTS-1:0]     m8_tvalid,
    input logic [NUM_8B_PORTS-1:0]     m8_tlast,
    input logic [NUM_8B_PORTS-1:0]     m8_tready,
    input logic [NUM_32B_PORTS*32-1:0] m32_tdata,
    input logic [NUM_32B_PORTS*4-1:0]  m32_tkeep,
    input logic [NUM_32B_PORTS-1:0]    m32_tvalid,
    input logic [NUM_32B_PORTS-1:0]    m32_tlast,
    input logic [NUM_32B_PORTS-1:0]    m32_tready,
    input logic [NUM_8B_PORTS-1:0]     overflow_8b,
    input logic [NUM_32B_PORTS-1:0]    overflow_32b
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // Idle outputs in reset and on the first edge out of it
    a_reset_idle: assert property (@(posedge clk_ifc) (!rst_n || $rose(rst_n)) |->
        (m8_tvalid == '0 && m32_tvalid == '0 && overflow_8b == '0 && overflow_32b == '0))
    else begin
        fail_count++;
        $error("Valid or overflow high during or right after reset");
    end

    ////////////////////
    // 8-bit ports

    for (genvar i = 0; i < NUM_8B_PORTS; i++) begin : g_8b
        a_hold: assert property (@(posedge clk_ifc) disable iff (!rst_n)
            m8_tvalid[i] && !m8_tready[i] |=>
                m8_tvalid[i] && $stable(m8_tdata[i*8 +: 8]) && $stable(m8_tlast[i]))
        else begin
            fail_count++;
            $error("8-bit port %0d changed its lane while stalled", i);
        end
    end

    ////////////////////
    // 32-bit ports

    for (genvar i = 0; i < NUM_32B_PORTS; i++) begin : g_32b
        a_hold: assert property (@(posedge clk_ifc) disable iff (!rst_n)
            m32_tvalid[i] && !m32_tready[i] |=>
                m32_tvalid[i] && $stable(m32_tdata[i*32 +: 32]) && $stable(m32_tlast[i]))
        else begin
            fail_count++;
            $error("32-bit port %0d changed its lane while stalled", i);
        end

        // Full lanes mid-packet and a contiguous low run on the final lane
        a_keep: assert property (@(posedge clk_ifc) disable iff (!rst_n)
            m32_tvalid[i] |-> (m32_tlast[i] ?
                (m32_tkeep[i*4 +: 4] inside {4'h1, 4'h3, 4'h7, 4'hf}) :
                (m32_tkeep[i*4 +: 4] == 4'hf)))
        else begin
            fail_count++;
            $error("32-bit port %0d shows a bad keep mask", i);
        end
    end

endmodule

bind mpls_egress mpls_egress_sva #(
    .NUM_8B_PORTS  (NUM_8B_PORTS),
    .NUM_32B_PORTS (NUM_32B_PORTS)
) u_sva (
    .clk_ifc (clk_ifc), .rst_n (rst_n),
    .m8_tdata (m8_tdata), .m8_tvalid (m8_tvalid), .m8_tlast (m8_tlast),
    .m8_tready (m8_tready), .m32_tdata (m32_tdata), .m32_tkeep (m32_tkeep),
    .m32_tvalid (m32_tvalid), .m32_tlast (m32_tlast), .m32_tready (m32_tready),
    .overflow_8b (overflow_8b), .overflow_32b (overflow_32b)
);

// ==== bench/mpls_egress_tb.sv ====
/* Testbench for mpls_egress with routed random-length packets under random
   sink stalls, then a forced overflow on one port and its recovery. */

module mpls_egress_tb import egress_cfg_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N8         = 3;
    localparam int N32        = 3;
    localparam int NP         = N8 + N32;
    localparam int ROUTE_PKTS = 24;
    localparam int DROP_MAX   = 8;
    localparam int HOLD_PORT  = 4;
    localparam logic [31:0] SEED = 32'h7401;
    // Packets times 64 bytes times 4 cycles times 100 ns with a margin of two
    localparam int WATCHDOG_NS = (ROUTE_PKTS + DROP_MAX + NP) * 64 * 4 * 100 * 2;

    logic                   clk_ifc;
    logic                   rst_n;
    logic [DATA_W-1:0]      s_tdata;
    logic [DATA_BYTES-1:0]  s_tkeep;
    logic                   s_tlast;
    logic                   s_tvalid;
    port_idx_t              s_tport;
    logic [N8*8-1:0]        m8_tdata;
    logic [N8-1:0]          m8_tvalid;
    logic [N8-1:0]          m8_tlast;
    logic [N8-1:0]          m8_tready;
    logic [N32*32-1:0]      m32_tdata;
    logic [N32*4-1:0]       m32_tkeep;
    logic [N32-1:0]         m32_tvalid;
    logic [N32-1:0]         m32_tlast;
    logic [N32-1:0]         m32_tready;
    logic [N8-1:0]          overflow_8b;
    logic [N32-1:0]         overflow_32b;

    // Scoreboard counters indexed by global port number
    int cnt [NP];
    int pkts [NP];
    int sent [NP];
    int ovf [NP];
    int tgt;
    int exp_len;
    int held;
    int errors;
    logic [31:0] len_state;
    logic [31:0] rdy_state;

    mpls_egress #(.NUM_8B_PORTS(N8), .NUM_32B_PORTS(N32), .BUF_WORDS(16)) UUT (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic report_mismatch(input string name, input int port,
                                   input int exp, input int act);
        errors++;
        $display("ERROR %s port %0d: expected %0d, actual %0d", name, port, exp, act);
    endtask

    // Byte n of a packet carries n mod 256
    task automatic check_byte(input string name, input int port, input logic [7:0] got);
        assert (got == 8'(cnt[port] % 256))
            else report_mismatch(name, port, cnt[port] % 256, got);
        cnt[port]++;
    endtask

    task automatic end_packet(input int port);
        assert (port == tgt) else report_mismatch("routing", port, tgt, port);
        assert (cnt[port] == exp_len)
            else report_mismatch("packet_length", port, exp_len, cnt[port]);
        pkts[port]++;
        cnt[port] = 0;
    endtask

    task automatic send_packet(input int port, input int len);
        int nbeats;
        nbeats = (len + 7) / 8;
        tgt = port;
        exp_len = len;
        sent[port]++;
        for (int b = 0; b < nbeats; b++) begin
            @(negedge clk_ifc);
            for (int k = 0; k < DATA_BYTES; k++) begin
                s_tdata[k*8 +: 8] = 8'((b * 8 + k) % 256);
                s_tkeep[k] = (b * 8 + k < len);
            end
            s_tvalid = 1'b1;
            s_tlast = (b == nbeats - 1);
            s_tport = port_idx_t'(port);
        end
        @(negedge clk_ifc);
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
    endtask

    task automatic wait_delivered(input int port);
        while (pkts[port] != sent[port] - ovf[port]) @(negedge clk_ifc);
    endtask

    initial begin
        clk_ifc = 1'b0;
        forever #50 clk_ifc = ~clk_ifc;
    end

    // Random sink stalls with the held port forced low
    always @(negedge clk_ifc) begin
        rdy_state = xorshift(rdy_state);
        for (int p = 0; p < N8; p++) begin
            m8_tready[p] = rdy_state[p * 3] && (held != p);
        end
        for (int p = 0; p < N32; p++) begin
            m32_tready[p] = rdy_state[16 + p * 3] && (held != N8 + p);
        end
    end

    ////////////////////
    // Output monitor

    always @(posedge clk_ifc) begin
        if (rst_n) begin
            for (int p = 0; p < N8; p++) begin
                if (overflow_8b[p]) ovf[p]++;
                if (m8_tvalid[p] && m8_tready[p]) begin
                    check_byte("data_8b", p, m8_tdata[p*8 +: 8]);
                    if (m8_tlast[p]) end_packet(p);
                end
            end
            for (int p = 0; p < N32; p++) begin
                if (overflow_32b[p]) ovf[N8 + p]++;
                if (m32_tvalid[p] && m32_tready[p]) begin
                    for (int k = 0; k < 4; k++) begin
                        if (m32_tkeep[p*4 + k]) begin
                            check_byte("data_32b", N8 + p, m32_tdata[p*32 + k*8 +: 8]);
                        end
                    end
                    if (m32_tlast[p]) end_packet(N8 + p);
                end
            end
        end
    end

    ////////////////////
    // Stimulus

    initial begin
        int n;
        s_tdata = '0;
        s_tkeep = '0;
        s_tlast = 1'b0;
        s_tvalid = 1'b0;
        s_tport = '0;
        m8_tready = '0;
        m32_tready = '0;
        held = -1;
        errors = 0;
        len_state = SEED;
        rdy_state = SEED;
        for (int p = 0; p < NP; p++) begin
            cnt[p] = 0;
            pkts[p] = 0;
            sent[p] = 0;
            ovf[p] = 0;
        end
        rst_n = 1'b0;
        repeat (5) @(negedge clk_ifc);
        rst_n = 1'b1;

        // Rotating ports with one packet in flight at a time
        for (int k = 0; k < ROUTE_PKTS; k++) begin
            len_state = xorshift(len_state);
            send_packet(k % NP, 8 + int'(len_state % 57));
            wait_delivered(k % NP);
        end

        // Stall one port until its buffer drops a packet
        held = HOLD_PORT;
        n = 0;
        while (ovf[HOLD_PORT] == 0 && n < DROP_MAX) begin
            send_packet(HOLD_PORT, 64);
            n++;
        end
        held = -1;
        wait_delivered(HOLD_PORT);

        // One more round including the recovered port
        for (int k = 0; k < NP; k++) begin
            len_state = xorshift(len_state);
            send_packet(k, 8 + int'(len_state % 57));
            wait_delivered(k);
        end

        for (int p = 0; p < NP; p++) begin
            assert (pkts[p] == sent[p] - ovf[p])
                else report_mismatch("packet_count", p, sent[p] - ovf[p], pkts[p]);
            if (p != HOLD_PORT) begin
                assert (ovf[p] == 0) else report_mismatch("stray_overflow", p, 0, ovf[p]);
            end
        end
        if (ovf[HOLD_PORT] == 0) begin
            errors++;
            $display("Held port %0d never reported an overflow", HOLD_PORT);
        end

        $display("Errors: %0d scoreboard, %0d assertion", errors, UUT.u_sva.fail_count);
        if (errors == 0 && UUT.u_sva.fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, packets stopped draining");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== vlog.f ====
verilog/egress_cfg_pkg.sv
verilog/axis_word_pkg.sv
verilog/egress_port_demux.sv
verilog/egress_pkt_buffer.sv
verilog/egress_width_conv.sv
verilog/mpls_egress.sv
bench/mpls_egress_sva.sv
bench/mpls_egress_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the egress testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module mpls_egress_tb -f vlog.f -o mpls_egress_sim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/mpls_egress_sim +verilator+error+limit+1000 > sim.log 2>&1
grep -qx "TEST OK" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
